// File: verilog/isa_pkg.sv
`default_nettype none

package isa_pkg;

	typedef logic [31:0] instr_t;
	typedef logic [4:0]  reg_addr_t; // register index.
	typedef logic [15:0] imm_t;
	typedef logic [25:0] jidx_t;     // jump target as a word index.

	// primary opcode, instr[31:26].
	typedef enum logic [5:0] {
		r_type = 6'h00,
		j      = 6'h02,
		beq    = 6'h04,
		addiu  = 6'h09,
		ori    = 6'h0d,
		lui    = 6'h0f,
		lw     = 6'h23,
		sw     = 6'h2b
	} opcode_t;

	// funct field of r_type, instr[5:0].
	typedef enum logic [5:0] {
		addu  = 6'h21,
		subu  = 6'h23,
		and_f = 6'h24,
		or_f  = 6'h25,
		slt   = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {
		op_add = 3'd0, // zero value, so a cleared control word adds.
		op_sub = 3'd1,
		op_and = 3'd2,
		op_or  = 3'd3,
		op_slt = 3'd4,
		op_lui = 3'd5
	} alu_op_t;

	typedef enum logic [1:0] {ext_zero = 2'd0, ext_sign = 2'd1, ext_upper = 2'd2} ext_mode_t;

endpackage

`default_nettype wire

// File: verilog/core_pkg.sv
`default_nettype none

package core_pkg;

	typedef logic [31:0] word_t;

	// decoded control for one instruction.
	typedef struct packed {
		logic                reg_write;
		logic                dst_is_rd;   // rd, else rt.
		logic                mem_to_reg;
		logic                alu_src_imm;
		logic                mem_write;
		logic                branch_eq;
		logic                jump;
		isa_pkg::alu_op_t    alu_op;
		isa_pkg::ext_mode_t  ext_mode;
	} ctrl_t;

	typedef struct packed {
		logic                valid;
		isa_pkg::reg_addr_t  addr;
		word_t               data;
	} wb_trace_t;

	typedef struct packed {
		logic   valid;
		word_t  addr; // byte address.
		word_t  data;
	} st_trace_t;

endpackage

`default_nettype wire

// File: verilog/control.sv
`timescale 1ns/100ps
`default_nettype none

module control (
	input  wire isa_pkg::instr_t instr,
	output core_pkg::ctrl_t      ctrl
);

	isa_pkg::opcode_t opcode;
	isa_pkg::funct_t  funct;

	assign opcode = isa_pkg::opcode_t'(instr[31:26]);
	assign funct  = isa_pkg::funct_t'(instr[5:0]);

	always_comb begin
		ctrl = '0; // nop unless decoded below.
		case (opcode)
			isa_pkg::r_type: begin
				ctrl.reg_write = 1'b1;
				ctrl.dst_is_rd = 1'b1;
				case (funct)
					isa_pkg::addu:  ctrl.alu_op = isa_pkg::op_add;
					isa_pkg::subu:  ctrl.alu_op = isa_pkg::op_sub;
					isa_pkg::and_f: ctrl.alu_op = isa_pkg::op_and;
					isa_pkg::or_f:  ctrl.alu_op = isa_pkg::op_or;
					isa_pkg::slt:   ctrl.alu_op = isa_pkg::op_slt;
					default:        ctrl = '0; // unknown funct.
				endcase
			end
			isa_pkg::addiu, isa_pkg::lw: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.ext_mode    = isa_pkg::ext_sign;
				ctrl.mem_to_reg  = (opcode == isa_pkg::lw);
			end
			isa_pkg::ori: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.alu_op      = isa_pkg::op_or; // zero-extended immediate.
			end
			isa_pkg::lui: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.alu_op      = isa_pkg::op_lui;
				ctrl.ext_mode    = isa_pkg::ext_upper;
			end
			isa_pkg::sw: begin
				ctrl.mem_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.ext_mode    = isa_pkg::ext_sign;
			end
			isa_pkg::beq: begin
				ctrl.branch_eq = 1'b1;
				ctrl.alu_op    = isa_pkg::op_sub;
				ctrl.ext_mode  = isa_pkg::ext_sign;
			end
			isa_pkg::j: ctrl.jump = 1'b1;
			default: ctrl = '0;
		endcase
	end

	// fetch_unit gives jump priority, so a word with both would lose its branch.
	always_comb begin
		assert (!(ctrl.branch_eq && ctrl.jump))
			else $error("control: branch_eq and jump both set");
	end

endmodule

`default_nettype wire

// File: verilog/fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_unit #(
	parameter int IM_WORDS = 256
) (
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire                   prog_we,
	input  wire core_pkg::word_t  prog_addr,
	input  wire isa_pkg::instr_t  prog_data,
	input  wire core_pkg::ctrl_t  ctrl,
	input  wire                   zero,
	output isa_pkg::instr_t       instr
);

	localparam int IM_AW = $clog2(IM_WORDS);

	isa_pkg::instr_t imem [IM_WORDS];
	core_pkg::word_t pc;
	core_pkg::word_t pc_plus4;
	core_pkg::word_t br_target;
	core_pkg::word_t j_target;
	core_pkg::word_t next_pc;
	isa_pkg::imm_t   imm;
	isa_pkg::jidx_t  jidx;

	assign imm  = instr[15:0];
	assign jidx = instr[25:0];

	assign pc_plus4  = pc + 32'd4;
	assign br_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
	assign j_target  = {pc_plus4[31:28], jidx, 2'b00}; // region of the delay slot.

	always_comb begin
		if (ctrl.jump)
			next_pc = j_target;
		else if (ctrl.branch_eq && zero)
			next_pc = br_target;
		else
			next_pc = pc_plus4;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			pc <= '0;
		else
			pc <= next_pc;
	end

	// program load, only while reset is held.
	always_ff @(posedge clk) begin
		if (!arst_n && prog_we)
			imem[prog_addr[IM_AW+1:2]] <= prog_data;
	end

	assign instr = imem[pc[IM_AW+1:2]];

	a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00);
	a_pc_in_range: assert property (@(posedge clk) disable iff (!arst_n)
		pc < core_pkg::word_t'(IM_WORDS * 4));

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
	input  wire                      clk,
	input  wire isa_pkg::reg_addr_t  rs,
	input  wire isa_pkg::reg_addr_t  rt,
	input  wire isa_pkg::reg_addr_t  wr_addr,
	input  wire core_pkg::word_t     wr_data,
	input  wire                      wr_en,
	output core_pkg::word_t          rs_data,
	output core_pkg::word_t          rt_data
);

	core_pkg::word_t regs [1:31]; // r0 is hardwired, no storage.

	always_ff @(posedge clk) begin
		if (wr_en && wr_addr != '0)
			regs[wr_addr] <= wr_data;
	end

	// reads are combinational, the write lands at the edge.
	always_comb begin
		if (rs == '0)
			rs_data = '0;
		else
			rs_data = regs[rs];
	end

	always_comb begin
		if (rt == '0)
			rt_data = '0;
		else
			rt_data = regs[rt];
	end

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
	input  wire core_pkg::ctrl_t  ctrl,
	input  wire isa_pkg::imm_t    imm,
	input  wire core_pkg::word_t  a,
	input  wire core_pkg::word_t  b,
	output core_pkg::word_t       result,
	output logic                  zero
);

	core_pkg::word_t ext_imm;
	core_pkg::word_t opnd_b;
	logic            lt;

	always_comb begin
		case (ctrl.ext_mode)
			isa_pkg::ext_sign:  ext_imm = {{16{imm[15]}}, imm};
			isa_pkg::ext_upper: ext_imm = {imm, 16'h0000};
			default:            ext_imm = {16'h0000, imm};
		endcase
	end

	assign opnd_b = ctrl.alu_src_imm ? ext_imm : b;
	assign lt     = $signed(a) < $signed(opnd_b); // signed slt.

	always_comb begin
		case (ctrl.alu_op)
			isa_pkg::op_add: result = a + opnd_b;
			isa_pkg::op_sub: result = a - opnd_b;
			isa_pkg::op_and: result = a & opnd_b;
			isa_pkg::op_or:  result = a | opnd_b;
			isa_pkg::op_slt: result = {31'b0, lt};
			isa_pkg::op_lui: result = opnd_b; // already shifted by the extender.
			default:         result = a + opnd_b;
		endcase
	end

	// beq looks at the registers, not the selected operand.
	assign zero = (a == b);

endmodule

`default_nettype wire

// File: verilog/data_mem.sv
`timescale 1ns/100ps
`default_nettype none

module data_mem #(
	parameter int DM_WORDS = 256
) (
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire core_pkg::word_t  addr,
	input  wire core_pkg::word_t  wdata,
	input  wire                   we,
	output core_pkg::word_t       rdata
);

	localparam int DM_AW = $clog2(DM_WORDS);

	core_pkg::word_t mem [DM_WORDS];

	// word index only, byte offset dropped.
	assign rdata = mem[addr[DM_AW+1:2]];

	always_ff @(posedge clk) begin
		if (we && arst_n)
			mem[addr[DM_AW+1:2]] <= wdata;
	end

	a_store_aligned: assert property (@(posedge clk) disable iff (!arst_n)
		we |-> addr[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: verilog/cpu.sv
`timescale 1ns/100ps
`default_nettype none

module cpu #(
	parameter int IM_WORDS = 256,
	parameter int DM_WORDS = 256
) (
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire                   prog_we,
	input  wire core_pkg::word_t  prog_addr,
	input  wire isa_pkg::instr_t  prog_data,
	output core_pkg::wb_trace_t   wb,
	output core_pkg::st_trace_t   st
);

	isa_pkg::instr_t    instr;
	core_pkg::ctrl_t    ctrl;
	core_pkg::word_t    rs_data;
	core_pkg::word_t    rt_data;
	core_pkg::word_t    alu_result;
	core_pkg::word_t    dm_rdata;
	logic               zero;
	isa_pkg::reg_addr_t wr_addr;
	core_pkg::word_t    wr_data;
	logic               wr_en;

	control control (.instr(instr), .ctrl(ctrl));

	fetch_unit #(.IM_WORDS(IM_WORDS)) fetch_unit (
		.clk(clk), .arst_n(arst_n),
		.prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
		.ctrl(ctrl), .zero(zero), .instr(instr)
	);

	// write-back selects.
	assign wr_addr = ctrl.dst_is_rd ? instr[15:11] : instr[20:16];
	assign wr_data = ctrl.mem_to_reg ? dm_rdata : alu_result;
	assign wr_en   = ctrl.reg_write && arst_n; // no writes while loading.

	reg_file reg_file (
		.clk(clk), .rs(instr[25:21]), .rt(instr[20:16]),
		.wr_addr(wr_addr), .wr_data(wr_data), .wr_en(wr_en),
		.rs_data(rs_data), .rt_data(rt_data)
	);

	alu alu (
		.ctrl(ctrl), .imm(instr[15:0]), .a(rs_data), .b(rt_data),
		.result(alu_result), .zero(zero)
	);

	data_mem #(.DM_WORDS(DM_WORDS)) data_mem (
		.clk(clk), .arst_n(arst_n), .addr(alu_result), .wdata(rt_data),
		.we(ctrl.mem_write), .rdata(dm_rdata)
	);

	// trace mirrors the write ports of this cycle.
	assign wb = '{valid: wr_en, addr: wr_addr, data: wr_data};
	assign st = '{valid: ctrl.mem_write && arst_n, addr: alu_result, data: rt_data};

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS = 40
) (
	output logic clk
);

	initial begin
		clk = 1'b0; // first rising edge at half a period.
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

// File: tests/cpu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_tb;

	localparam int CLK_PERIOD  = 40;
	localparam int DRIVE_DELAY = 2;
	localparam int MAX_LINES   = 1000;

	logic                clk;
	logic                arst_n;
	logic                prog_we;
	core_pkg::word_t     prog_addr;
	isa_pkg::instr_t     prog_data;
	core_pkg::wb_trace_t wb;
	core_pkg::st_trace_t st;

	core_pkg::word_t     load_addr_q [$];
	isa_pkg::instr_t     load_word_q [$];
	core_pkg::wb_trace_t exp_wb_q [$];
	core_pkg::st_trace_t exp_st_q [$];
	string               test_name;
	int                  run_cycles;
	bit                  test_open;
	int                  test_errors;
	int                  total_errors;
	int                  tests_run;
	int                  tests_failed;

	tb_clock #(.PERIOD_NS(CLK_PERIOD)) clock_gen (.clk(clk));

	cpu #(.IM_WORDS(256), .DM_WORDS(256)) dut0 (
		.clk(clk), .arst_n(arst_n), .prog_we(prog_we),
		.prog_addr(prog_addr), .prog_data(prog_data), .wb(wb), .st(st)
	);

	task automatic wait_drive_point();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	// 1 ns before the next rising edge.
	task automatic wait_sample_point();
		#(CLK_PERIOD - DRIVE_DELAY - 1);
	endtask

	task automatic check_wb(input core_pkg::wb_trace_t got, input core_pkg::wb_trace_t exp);
		if (got.addr !== exp.addr) begin
			$display("MISMATCH wb.addr got %h expected %h", got.addr, exp.addr);
			test_errors++;
		end
		if (got.data !== exp.data) begin
			$display("MISMATCH wb.data got %h expected %h", got.data, exp.data);
			test_errors++;
		end
	endtask

	task automatic check_st(input core_pkg::st_trace_t got, input core_pkg::st_trace_t exp);
		if (got.addr !== exp.addr) begin
			$display("MISMATCH st.addr got %h expected %h", got.addr, exp.addr);
			test_errors++;
		end
		if (got.data !== exp.data) begin
			$display("MISMATCH st.data got %h expected %h", got.data, exp.data);
			test_errors++;
		end
	endtask

	task automatic check_quiet();
		if (wb.valid !== 1'b0 || st.valid !== 1'b0) begin
			$display("%s: trace event seen while reset is held", test_name);
			test_errors++;
		end
	endtask

	task automatic sample_trace();
		if (wb.valid) begin
			if (exp_wb_q.size() == 0) begin
				$display("%s: unexpected register write to r%0d", test_name, wb.addr);
				test_errors++;
			end else
				check_wb(wb, exp_wb_q.pop_front());
		end
		if (st.valid) begin
			if (exp_st_q.size() == 0) begin
				$display("%s: unexpected store to address %h", test_name, st.addr);
				test_errors++;
			end else
				check_st(st, exp_st_q.pop_front());
		end
	endtask

	// entered at a drive point, leaves the DUT in reset.
	task automatic run_test();
		int c;
		int i;
		test_errors = 0;
		arst_n = 1'b0;
		prog_we = 1'b0;
		for (c = 0; c < 2; c++) begin
			wait_sample_point();
			check_quiet();
			wait_drive_point();
		end
		for (i = 0; i < load_addr_q.size(); i++) begin
			prog_we = 1'b1;
			prog_addr = load_addr_q[i];
			prog_data = load_word_q[i];
			wait_sample_point();
			check_quiet();
			wait_drive_point();
		end
		prog_we = 1'b0;
		arst_n = 1'b1;
		for (c = 0; c < run_cycles; c++) begin // cycle budget is the timeout.
			wait_sample_point();
			sample_trace();
			wait_drive_point();
		end
		if (exp_wb_q.size() != 0) begin
			$display("%s: %0d register writes never happened", test_name, exp_wb_q.size());
			test_errors++;
		end
		if (exp_st_q.size() != 0) begin
			$display("%s: %0d stores never happened", test_name, exp_st_q.size());
			test_errors++;
		end
		arst_n = 1'b0;
		if (test_errors == 0)
			$display("test %s: ok", test_name);
		else
			$display("test %s: %0d errors", test_name, test_errors);
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		total_errors += test_errors;
		load_addr_q.delete();
		load_word_q.delete();
		exp_wb_q.delete();
		exp_st_q.delete();
	endtask

	initial begin
		int              fd;
		int              n;
		int              line_no;
		string           line;
		string           tag;
		string           name;
		core_pkg::word_t v1;
		core_pkg::word_t v2;
		arst_n = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		test_name = "none";
		wait_drive_point();
		fd = $fopen("tests/cpu_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open tests/cpu_tests.txt");
			total_errors++;
		end else begin
			line_no = 0;
			while (!$feof(fd) && line_no < MAX_LINES) begin
				line = "";
				n = $fgets(line, fd);
				line_no++;
				n = $sscanf(line, "%s", tag);
				if (n < 1 || tag[0] == "#") begin
					n = 0; // blank or comment line.
				end else if (tag == "T") begin
					if (test_open)
						run_test();
					n = $sscanf(line, "%s %s", tag, name);
					test_name = name;
					run_cycles = 0;
					test_open = 1'b1;
				end else if (tag == "R") begin
					n = $sscanf(line, "%s %d", tag, run_cycles);
				end else begin
					n = $sscanf(line, "%s %h %h", tag, v1, v2);
					if (tag == "P") begin
						load_addr_q.push_back(v1);
						load_word_q.push_back(v2);
					end else if (tag == "W")
						exp_wb_q.push_back('{1'b1, v1[4:0], v2});
					else if (tag == "S")
						exp_st_q.push_back('{1'b1, v1, v2});
					else begin
						$display("unknown entry on line %0d of the tests file", line_no);
						total_errors++;
					end
				end
			end
			$fclose(fd);
			if (test_open)
				run_test();
		end
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
		if (total_errors == 0 && tests_run > 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/cpu_tests.txt
# T name | P byte_addr word | R cycles (decimal) | W reg value | S byte_addr value
# other numbers hex; W and S lines list the expected events in execution order.
T alu_imm
P 00 24018000
P 04 34028123
P 08 3c03abcd
P 0c 00432021
P 10 00412823
P 14 00243024
P 18 00223825
P 1c 0022402a
P 20 24000055
P 24 00025021
P 28 0800000a
R 14
W 01 ffff8000
W 02 00008123
W 03 abcd0000
W 04 abcd8123
W 05 00010123
W 06 abcd8000
W 07 ffff8123
W 08 00000001
W 00 00000055
W 0a 00008123
T mem_branch_jump
P 00 24010040
P 04 ac210008
P 08 8c220008
P 0c 10220001
P 10 24030001
P 14 10200001
P 18 08000008
P 1c 24030002
P 20 fc221800
P 24 24030003
P 28 0800000a
R 14
W 01 00000040
S 00000048 00000040
W 02 00000040
W 03 00000003

// File: files.f
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/control.sv
verilog/fetch_unit.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/data_mem.sv
verilog/cpu.sv
tests/tb_clock.sv
tests/cpu_tb.sv

// File: Makefile
SIM := obj_dir/Vcpu_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f files.f --top-module cpu_tb
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
